//--- logic/mem_geom_pkg.sv
`default_nettype none

package mem_geom_pkg;

  // Width of one data word and of its bit write mask.
  localparam int unsigned WORD_W = 64;

  // Words held by each bank.
  localparam int unsigned BANK_ELS = 32;

  localparam int unsigned NUM_BANKS = 4; // Banks in the memory.

  localparam int unsigned MEM_ELS = BANK_ELS * NUM_BANKS; // Total words, 128.

  // Derived address widths.
  localparam int unsigned LOCAL_AW   = $clog2(BANK_ELS);  // 5 bits.
  localparam int unsigned BANK_IDX_W = $clog2(NUM_BANKS); // 2 bits.

  // One spare bit above the in-range space, so 128 to 255 decode as errors.
  localparam int unsigned ADDR_W = 8;

endpackage

`default_nettype wire

//--- logic/mem_req_pkg.sv
`default_nettype none

package mem_req_pkg;

  import mem_geom_pkg::*;

  // Request as seen at the memory boundary, 138 bits.
  typedef struct packed {
    logic                v;    // Request strobe.
    logic                w;    // Write when high, read when low.
    logic [ADDR_W-1:0]   addr; // Word address.
    logic [WORD_W-1:0]   data; // Write data.
    logic [WORD_W-1:0]   mask; // Bit write mask, 1 writes the bit.
  } mem_req_t;

  // Request as seen by one bank, 135 bits.
  // Only v differs between banks, the rest is broadcast.
  typedef struct packed {
    logic                v;
    logic                w;
    logic [LOCAL_AW-1:0] addr; // Word address inside the bank.
    logic [WORD_W-1:0]   data;
    logic [WORD_W-1:0]   mask;
  } bank_req_t;

endpackage

`default_nettype wire

//--- logic/bank_select.sv
`default_nettype none
`timescale 1ns/10ps

module bank_select
  import mem_geom_pkg::*;
  import mem_req_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_req_t              req_i,
  output bank_req_t             bank_req_o [NUM_BANKS],
  output logic [BANK_IDX_W-1:0] rd_bank_o,
  output logic                  addr_err_o
);

  logic [BANK_IDX_W-1:0] bank_idx;
  logic [LOCAL_AW-1:0]   local_addr;
  logic                  in_range;
  logic                  rd_accept;
  logic                  req_reject;
  logic [BANK_IDX_W-1:0] rd_bank_q;
  logic                  addr_err_q;

  // Upper bits pick the bank, lower bits the word inside it.
  assign bank_idx   = req_i.addr[LOCAL_AW +: BANK_IDX_W];
  assign local_addr = req_i.addr[LOCAL_AW-1:0];

  assign in_range   = (req_i.addr < ADDR_W'(MEM_ELS));
  assign rd_accept  = req_i.v && !req_i.w && in_range; // Read that a bank serves.
  assign req_reject = req_i.v && !in_range;

  // Broadcast payload, strobe only the addressed bank.
  always_comb
  begin
    for (int i = 0; i < NUM_BANKS; i++)
    begin
      bank_req_o[i].v    = req_i.v && in_range && (bank_idx == BANK_IDX_W'(i));
      bank_req_o[i].w    = req_i.w;
      bank_req_o[i].addr = local_addr;
      bank_req_o[i].data = req_i.data;
      bank_req_o[i].mask = req_i.mask;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_bank_q  <= '0;
      addr_err_q <= 1'b0;
    end
    else
    begin
      addr_err_q <= req_reject; // One cycle pulse per rejected request.
      if (rd_accept)
      begin
        rd_bank_q <= bank_idx; // Steers the return mux until the next read.
      end
    end
  end

  assign rd_bank_o  = rd_bank_q;
  assign addr_err_o = addr_err_q;

endmodule

`default_nettype wire

//--- logic/mask_write_bank.sv
`default_nettype none
`timescale 1ns/10ps

module mask_write_bank
  import mem_geom_pkg::*;
  import mem_req_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  bank_req_t         req_i,
  output logic [WORD_W-1:0] rd_data_o
);

  logic [WORD_W-1:0] mem_q [BANK_ELS];
  logic [WORD_W-1:0] old_word;
  logic [WORD_W-1:0] wr_word;
  logic              wr_en;
  logic              rd_en;
  logic [WORD_W-1:0] rd_data_q;

  // Single port, so one strobe serves either a read or a write.
  assign wr_en = req_i.v && req_i.w;
  assign rd_en = req_i.v && !req_i.w;

  assign old_word = mem_q[req_i.addr];

  // Keep old bits where the mask is 0, take new data where it is 1.
  always_comb
  begin
    for (int b = 0; b < WORD_W; b++)
    begin
      if (req_i.mask[b])
      begin
        wr_word[b] = req_i.data[b];
      end
      else
      begin
        wr_word[b] = old_word[b];
      end
    end
  end

  // Storage array.
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      mem_q[req_i.addr] <= wr_word;
    end
  end

  // Last read word, kept across writes and idle cycles.
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_data_q <= '0;
    end
    else if (rd_en)
    begin
      rd_data_q <= old_word; // Visible the cycle after the read edge.
    end
  end

  assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- logic/read_return_mux.sv
`default_nettype none
`timescale 1ns/10ps

module read_return_mux
  import mem_geom_pkg::*;
(
  input  logic [WORD_W-1:0]     bank_data_i [NUM_BANKS],
  input  logic [BANK_IDX_W-1:0] rd_bank_i,
  output logic [WORD_W-1:0]     data_o
);

  logic [NUM_BANKS-1:0] sel;
  logic [WORD_W-1:0]    sel_data;

  // One-hot decode of the bank that served the last read.
  always_comb
  begin
    for (int i = 0; i < NUM_BANKS; i++)
    begin
      sel[i] = (rd_bank_i == BANK_IDX_W'(i));
    end
  end

  // AND-OR select, exactly one term is live.
  always_comb
  begin
    sel_data = '0;
    for (int i = 0; i < NUM_BANKS; i++)
    begin
      sel_data = sel_data | (bank_data_i[i] & {WORD_W{sel[i]}});
    end
  end

  assign data_o = sel_data;

endmodule

`default_nettype wire

//--- logic/banked_mask_mem.sv
`default_nettype none
`timescale 1ns/10ps

module banked_mask_mem
  import mem_geom_pkg::*;
  import mem_req_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  mem_req_t          req_i,
  output logic [WORD_W-1:0] data_o,
  output logic              addr_err_o
);

  bank_req_t             bank_req  [NUM_BANKS]; // Per-bank requests.
  logic [WORD_W-1:0]     bank_data [NUM_BANKS]; // Held read word of each bank.
  logic [BANK_IDX_W-1:0] rd_bank;

  // Address decode and range check.
  bank_select u_bank_select (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .bank_req_o (bank_req),
    .rd_bank_o  (rd_bank),
    .addr_err_o (addr_err_o)
  );

  // Identical banks, one strobe each.
  for (genvar i = 0; i < NUM_BANKS; i++)
  begin : g_bank
    mask_write_bank u_mask_write_bank (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .req_i     (bank_req[i]),
      .rd_data_o (bank_data[i])
    );
  end

  // Return path follows the last accepted read.
  read_return_mux u_read_return_mux (
    .bank_data_i (bank_data),
    .rd_bank_i   (rd_bank),
    .data_o      (data_o)
  );

endmodule

`default_nettype wire

//--- verif/mem_tests.svh
`ifndef MEM_TESTS_SVH
`define MEM_TESTS_SVH

// Outputs straight after reset, before any request.
task automatic reset_state_values();
  cur_test = "reset_state_values";
  @(negedge clk_i);
  check_outputs(); // Model starts at zero with no error.
  send_idle();
  send_idle();
endtask

// Every word written in full, then read back in order.
task automatic full_write_readback();
  logic [31:0]       r_hi;
  logic [31:0]       r_lo;
  logic [ADDR_W-1:0] a;
  cur_test = "full_write_readback";
  for (int i = 0; i < MEM_ELS; i++)
  begin
    a    = ADDR_W'(i);
    r_hi = $urandom();
    r_lo = $urandom();
    // Low byte carries the address so all words differ.
    send_request(build_request(1'b1, a, {r_hi, r_lo[31:8], a}, '1));
  end
  for (int i = 0; i < MEM_ELS; i++)
  begin
    send_request(build_request(1'b0, ADDR_W'(i), '0, '0));
  end
  send_idle();
endtask

// Masked writes over known words, each read back at once.
task automatic random_mask_writes();
  logic [ADDR_W-1:0] a;
  logic [WORD_W-1:0] mask;
  cur_test = "random_mask_writes";
  for (int i = 0; i < N_MASK; i++)
  begin
    a    = ADDR_W'($urandom_range(MEM_ELS - 1, 0));
    mask = {$urandom(), $urandom()};
    if (i % 8 == 0)
    begin
      mask = '0; // Word must stay as it was.
    end
    else if (i % 8 == 4)
    begin
      mask = '1;
    end
    send_request(build_request(1'b1, a, {$urandom(), $urandom()}, mask));
    send_request(build_request(1'b0, a, '0, '0));
  end
  send_idle();
endtask

// Held word survives writes and idle cycles until the next read.
task automatic read_hold_across_writes();
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;
  cur_test = "read_hold_across_writes";
  for (int n = 0; n < N_HOLD; n++)
  begin
    rd_addr = ADDR_W'($urandom_range(MEM_ELS - 1, 0));
    send_request(build_request(1'b0, rd_addr, '0, '0));
    for (int k = 0; k < HOLD_WRITES; k++)
    begin
      // Even steps overwrite the word just read, odd steps hit other banks.
      if (k % 2 == 0)
      begin
        wr_addr = rd_addr;
      end
      else
      begin
        wr_addr = ADDR_W'((int'(rd_addr) + k * BANK_ELS) % MEM_ELS);
      end
      send_request(build_request(1'b1, wr_addr, {$urandom(), $urandom()}, '1));
    end
    repeat (HOLD_IDLE)
    begin
      send_idle();
    end
    // New read from the next bank replaces the held word.
    send_request(build_request(1'b0, ADDR_W'((int'(rd_addr) + BANK_ELS) % MEM_ELS),
                               '0, '0));
  end
  send_idle();
endtask

// Requests above the memory raise the error and touch nothing.
task automatic out_of_range_rejection();
  logic [ADDR_W-1:0] bad_addr;
  logic [ADDR_W-1:0] alias_addr;
  logic [ADDR_W-1:0] hold_addr;
  cur_test = "out_of_range_rejection";
  for (int n = 0; n < N_OOR; n++)
  begin
    bad_addr   = ADDR_W'($urandom_range(2 ** ADDR_W - 1, MEM_ELS));
    alias_addr = bad_addr - ADDR_W'(MEM_ELS);
    hold_addr  = ADDR_W'($urandom_range(MEM_ELS - 1, 0));
    send_request(build_request(1'b0, hold_addr, '0, '0)); // Known word on data_o.
    send_request(build_request(1'b1, bad_addr, {$urandom(), $urandom()}, '1));
    send_request(build_request(1'b0, bad_addr, '0, '0));
    send_idle();
    send_request(build_request(1'b0, alias_addr, '0, '0));
  end
  send_idle();
endtask

// One request every cycle, mixed reads and writes across banks.
task automatic mixed_back_to_back();
  logic [ADDR_W-1:0] a;
  logic              w;
  cur_test = "mixed_back_to_back";
  for (int n = 0; n < N_MIXED; n++)
  begin
    if ($urandom_range(7, 0) == 0)
    begin
      a = ADDR_W'($urandom_range(2 ** ADDR_W - 1, MEM_ELS));
    end
    else
    begin
      a = ADDR_W'($urandom_range(MEM_ELS - 1, 0));
    end
    w = 1'($urandom_range(1, 0));
    send_request(build_request(w, a, {$urandom(), $urandom()}, {$urandom(), $urandom()}));
  end
  send_idle();
endtask

`endif

//--- verif/banked_mask_mem_tb.sv
`default_nettype none
`timescale 1ns/10ps

module banked_mask_mem_tb
  import mem_geom_pkg::*;
  import mem_req_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 10;
  localparam int MEM_AW     = LOCAL_AW + BANK_IDX_W; // Index into the flat model.

  // Test lengths, also used to size the watchdog.
  localparam int N_MASK      = 64;
  localparam int N_HOLD      = 4;
  localparam int HOLD_WRITES = 6;
  localparam int HOLD_IDLE   = 4;
  localparam int N_OOR       = 16;
  localparam int N_MIXED     = 400;

  localparam int TEST_CYCLES = RST_CYCLES + 3 + (2 * MEM_ELS + 1) + (2 * N_MASK + 1)
    + N_HOLD * (HOLD_WRITES + HOLD_IDLE + 2) + 1 + (5 * N_OOR + 1) + (N_MIXED + 1);
  localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

  logic              clk_i;
  logic              rst_n_i;
  mem_req_t          req_i;
  logic [WORD_W-1:0] data_o;
  logic              addr_err_o;

  // Reference model state.
  logic [WORD_W-1:0] model_mem [MEM_ELS];
  logic [WORD_W-1:0] exp_data; // Word data_o must hold.
  logic              exp_err;  // Expected addr_err_o.
  string             cur_test;

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  banked_mask_mem u_banked_mask_mem (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .data_o     (data_o),
    .addr_err_o (addr_err_o)
  );

  task automatic stop_on_failure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  function automatic mem_req_t build_request(input logic w, input logic [ADDR_W-1:0] addr,
                                             input logic [WORD_W-1:0] data,
                                             input logic [WORD_W-1:0] mask);
    mem_req_t r;
    r.v    = 1'b1;
    r.w    = w;
    r.addr = addr;
    r.data = data;
    r.mask = mask;
    return r;
  endfunction

  // Mask rule and read hold, one request at a time.
  task automatic update_model(input mem_req_t r);
    logic in_range;
    in_range = (r.addr < ADDR_W'(MEM_ELS));
    exp_err  = r.v && !in_range;
    if (r.v && in_range)
    begin
      if (r.w)
      begin
        model_mem[r.addr[MEM_AW-1:0]] = (model_mem[r.addr[MEM_AW-1:0]] & ~r.mask)
                                        | (r.data & r.mask);
      end
      else
      begin
        exp_data = model_mem[r.addr[MEM_AW-1:0]];
      end
    end
  endtask

  task automatic check_outputs();
    assert (data_o === exp_data)
    else
    begin
      $display("ERROR %s: data_o expected %h actual %h", cur_test, exp_data, data_o);
      stop_on_failure();
    end
    assert (addr_err_o === exp_err)
    else
    begin
      $display("ERROR %s: addr_err_o expected %b actual %b", cur_test, exp_err, addr_err_o);
      stop_on_failure();
    end
  endtask

  // Drive on the rising edge, check the previous request at the falling edge.
  task automatic send_request(input mem_req_t r);
    @(posedge clk_i);
    req_i <= r;
    @(negedge clk_i);
    check_outputs();
    update_model(r);
  endtask

  task automatic send_idle();
    mem_req_t idle;
    idle = '0;
    send_request(idle);
  endtask

  `include "mem_tests.svh"

  initial
  begin
    void'($urandom(32'h1afdba37));
    rst_n_i  <= 1'b0;
    req_i    <= '0;
    exp_data = '0;
    exp_err  = 1'b0;
    cur_test = "reset";
    repeat (RST_CYCLES)
    begin
      @(posedge clk_i);
    end
    rst_n_i <= 1'b1;
    reset_state_values();
    full_write_readback();
    random_mask_writes();
    read_hold_across_writes();
    out_of_range_rejection();
    mixed_back_to_back();
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    stop_on_failure();
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verif
logic/mem_geom_pkg.sv
logic/mem_req_pkg.sv
logic/bank_select.sv
logic/mask_write_bank.sv
logic/read_return_mux.sv
logic/banked_mask_mem.sv
verif/banked_mask_mem_tb.sv

//--- Makefile
TOP := banked_mask_mem_tb
SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): sources.f $(wildcard logic/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -f sources.f

# The grep status decides pass or fail.
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
